// ==== build.f ====
+incdir+hw
hw/pet_pkg.sv
hw/bus_slot_if.sv
hw/pet_timing.sv
hw/bus_sequencer.sv
hw/video_shifter.sv
hw/pet_core.sv
tb/tb_pet_core.sv

// ==== hw/bus_sequencer.sv ====
// ********************
// Shared RAM with per-slot access for CPU, SPI and video
// One access per cycle through a single port
// ********************

`include "pet_defs.svh"

module bus_sequencer import pet_pkg::*; (
    input  logic               sys_clock_i,
    input  logic               rst_i,
    bus_slot_if.sequencer      slot_i,
    input  logic [`RAM_AW-1:0] cpu_addr_i,
    input  logic [7:0]         cpu_data_i,
    input  logic               cpu_we_i,
    output logic [7:0]         cpu_data_o,
    input  logic               spi_wr_i,
    input  logic [`RAM_AW-1:0] spi_addr_i,
    input  logic [7:0]         spi_data_i,
    output logic               spi_done_o,
    output logic               fetch_valid_o,
    output fetch_kind_e        fetch_kind_o,
    output logic [7:0]         fetch_data_o
);

    localparam int DEPTH = 1 << `RAM_AW;

    function automatic bus_owner_e slot_owner(input bus_slot_e slot);
        case (slot)
            SLOT_CPU_1, SLOT_CPU_2: return OWNER_CPU;
            SLOT_SPI_1, SLOT_SPI_2: return OWNER_SPI;
            default:                return OWNER_VIDEO;
        endcase
    endfunction

    logic [7:0]         ram [DEPTH];
    logic [`RAM_AW-1:0] video_ptr_q;
    logic [`RAM_AW-1:0] mem_addr;
    bus_owner_e         owner;
    logic               cpu_acc;
    logic               spi_acc;
    logic               video_acc;

    assign owner     = slot_owner(slot_i.slot);
    assign cpu_acc   = slot_i.cpu_wr_strobe && (owner == OWNER_CPU);
    assign spi_acc   = slot_i.slot_valid && (owner == OWNER_SPI) && spi_wr_i;  // Pending request only
    assign video_acc = slot_i.slot_valid && (owner == OWNER_VIDEO);

    always_comb begin
        unique case (owner)
            OWNER_CPU: mem_addr = cpu_addr_i;
            OWNER_SPI: mem_addr = spi_addr_i;
            default:   mem_addr = video_ptr_q;
        endcase
    end

    always_ff @(posedge sys_clock_i) begin
        if ((cpu_acc && cpu_we_i) || spi_acc) begin
            ram[mem_addr] <= (owner == OWNER_SPI) ? spi_data_i : cpu_data_i;
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (rst_i) begin
            cpu_data_o    <= '0;
            spi_done_o    <= 1'b0;
            fetch_valid_o <= 1'b0;
            fetch_kind_o  <= FETCH_CHAR;
            fetch_data_o  <= '0;
            video_ptr_q   <= '0;
        end else begin
            spi_done_o    <= spi_acc;
            fetch_valid_o <= video_acc;
            if (cpu_acc && !cpu_we_i) begin
                cpu_data_o <= ram[mem_addr];  // Held until the next CPU read
            end
            if (video_acc) begin
                // VIDEO_1 and VIDEO_3 carry characters, the others attributes
                fetch_kind_o <= ((slot_i.slot == SLOT_VIDEO_1) || (slot_i.slot == SLOT_VIDEO_3))
                                ? FETCH_CHAR : FETCH_ATTR;
                fetch_data_o <= ram[mem_addr];
                video_ptr_q  <= video_ptr_q + 1'b1;  // Wraps at the top of RAM
            end
        end
    end

endmodule

// ==== hw/bus_slot_if.sv ====
// ********************
// Slot and strobe bundle from the timing stage
// Read by the bus sequencer and the video shifter
// ********************

interface bus_slot_if import pet_pkg::*; ();

    bus_slot_e slot;           // Current slot, receivers derive the owner
    logic      slot_valid;     // First cycle of a video or SPI slot
    logic      load_sr1;       // Attribute output load
    logic      load_sr2;       // Pixel shift register load
    logic      pixel_en;       // One pixel every fourth cycle
    logic      cpu_wr_strobe;  // CPU access point in the window

    modport timing (
        output slot, slot_valid, load_sr1, load_sr2, pixel_en, cpu_wr_strobe
    );

    modport sequencer (
        input slot, slot_valid, cpu_wr_strobe
    );

    modport shifter (
        input load_sr1, load_sr2, pixel_en
    );

endinterface

// ==== hw/pet_core.sv ====
// ********************
// Top level: timing, bus sequencer and video shifter
// ********************

`include "pet_defs.svh"

module pet_core import pet_pkg::*; (
    input  logic               sys_clock_i,
    input  logic               rst_i,
    output logic               cpu_be_o,
    output logic               cpu_clock_o,
    input  logic [`RAM_AW-1:0] cpu_addr_i,
    input  logic [7:0]         cpu_data_i,
    input  logic               cpu_we_i,
    output logic [7:0]         cpu_data_o,
    input  logic               spi_wr_i,
    input  logic [`RAM_AW-1:0] spi_addr_i,
    input  logic [7:0]         spi_data_i,
    output logic               spi_done_o,
    output logic               pixel_o,
    output logic [7:0]         attr_o
);

    bus_slot_if slot_bus ();

    logic        fetch_valid;
    fetch_kind_e fetch_kind;
    logic [7:0]  fetch_data;

    pet_timing u_timing (
        .sys_clock_i (sys_clock_i),
        .rst_i       (rst_i),
        .cpu_be_o    (cpu_be_o),
        .cpu_clock_o (cpu_clock_o),
        .slot_o      (slot_bus)
    );

    bus_sequencer u_sequencer (
        .sys_clock_i   (sys_clock_i),
        .rst_i         (rst_i),
        .slot_i        (slot_bus),
        .cpu_addr_i    (cpu_addr_i),
        .cpu_data_i    (cpu_data_i),
        .cpu_we_i      (cpu_we_i),
        .cpu_data_o    (cpu_data_o),
        .spi_wr_i      (spi_wr_i),
        .spi_addr_i    (spi_addr_i),
        .spi_data_i    (spi_data_i),
        .spi_done_o    (spi_done_o),
        .fetch_valid_o (fetch_valid),
        .fetch_kind_o  (fetch_kind),
        .fetch_data_o  (fetch_data)
    );

    video_shifter u_shifter (
        .sys_clock_i   (sys_clock_i),
        .rst_i         (rst_i),
        .slot_i        (slot_bus),
        .fetch_valid_i (fetch_valid),
        .fetch_kind_i  (fetch_kind),
        .fetch_data_i  (fetch_data),
        .pixel_o       (pixel_o),
        .attr_o        (attr_o)
    );

endmodule

// ==== hw/pet_defs.svh ====
// ********************
// Clock, CPU bus timing and memory size constants
// Include where the timing stage or the RAM width is needed
// ********************

`ifndef PET_DEFS_SVH
`define PET_DEFS_SVH

// System clock, one cycle is 15.625 ns
`define SYS_CLOCK_MHZ 64

// CPU bus timing in ns
`define CPU_TBVD_NS 30  // BE to valid data
`define CPU_TPWH_NS 62  // Clock pulse width high
`define CPU_TDH_NS  10  // Data hold after clock fall
`define IOTX_NS     11  // Bus transceiver delay

// Shared RAM, 256 bytes
`define RAM_AW 8

// Master frame of 64 cycles
`define FRAME_BITS 6

`endif

// ==== hw/pet_pkg.sv ====
// ********************
// Types shared by the timing, sequencer and video stages
// ********************

package pet_pkg;

    // Eight 8-cycle slots of one frame, in bus order
    typedef enum logic [2:0] {
        SLOT_CPU_1   = 3'd0,
        SLOT_CPU_2   = 3'd1,
        SLOT_VIDEO_1 = 3'd2,
        SLOT_VIDEO_2 = 3'd3,
        SLOT_SPI_1   = 3'd4,
        SLOT_VIDEO_3 = 3'd5,
        SLOT_VIDEO_4 = 3'd6,
        SLOT_SPI_2   = 3'd7
    } bus_slot_e;

    typedef enum logic [1:0] {
        OWNER_CPU   = 2'd0,
        OWNER_VIDEO = 2'd1,
        OWNER_SPI   = 2'd2
    } bus_owner_e;

    // Tag on a video RAM read
    typedef enum logic [0:0] {
        FETCH_CHAR = 1'b0,
        FETCH_ATTR = 1'b1
    } fetch_kind_e;

endpackage

// ==== hw/pet_timing.sv ====
// ********************
// Master frame timing: 64-cycle counter, bus slots and CPU window
// Drives the slot bundle for the sequencer and the shifter
// ********************

`include "pet_defs.svh"

module pet_timing import pet_pkg::*; (
    input  logic       sys_clock_i,
    input  logic       rst_i,
    output logic       cpu_be_o,
    output logic       cpu_clock_o,
    bus_slot_if.timing slot_o
);

    localparam int CW = `FRAME_BITS;

    // Whole cycles covering a delay, plus one for board margin
    function automatic int ns_to_cycles(input int time_ns);
        return (time_ns * `SYS_CLOCK_MHZ + 999) / 1000 + 1;
    endfunction

    // Window edges as frame counts
    localparam logic [CW-1:0] CPU_BE_START  = '0;
    localparam logic [CW-1:0] CPU_PHI_START =
        CW'(int'(CPU_BE_START) + ns_to_cycles(`CPU_TBVD_NS + `IOTX_NS));
    localparam logic [CW-1:0] CPU_PHI_END   =
        CW'(int'(CPU_PHI_START) + ns_to_cycles(`CPU_TPWH_NS));
    localparam logic [CW-1:0] CPU_WR_STROBE = CPU_PHI_END - CW'(2);
    localparam logic [CW-1:0] CPU_BE_END    =
        CW'(int'(CPU_PHI_END) + ns_to_cycles(`CPU_TDH_NS));
    localparam logic [CW-1:0] CPU_BE_OFF    = CPU_BE_END + CW'(1);  // BE spans the last hold count

    logic [CW-1:0] count_q;
    bus_slot_e     slot_q;
    logic          slot_start_q;
    logic          pixel_en_q;
    logic          wr_strobe_q;

    always_ff @(posedge sys_clock_i) begin
        if (rst_i) begin
            count_q      <= '1;          // First count after reset is 0
            slot_q       <= SLOT_SPI_2;  // Wraps to CPU_1 at count 1
            slot_start_q <= 1'b0;
            pixel_en_q   <= 1'b0;
        end else begin
            count_q      <= count_q + 1'b1;
            slot_start_q <= (count_q[2:0] == 3'd0);
            pixel_en_q   <= (count_q[1:0] == 2'd0);
            if (count_q[2:0] == 3'd0) begin
                slot_q <= bus_slot_e'(slot_q + 3'd1);
            end
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (rst_i) begin
            cpu_be_o    <= 1'b0;
            cpu_clock_o <= 1'b0;
            wr_strobe_q <= 1'b0;
        end else begin
            wr_strobe_q <= 1'b0;
            unique case (count_q)
                CPU_BE_START: begin
                    cpu_be_o <= 1'b1;
                end
                CPU_PHI_START: begin
                    cpu_clock_o <= 1'b1;
                end
                CPU_WR_STROBE: begin
                    wr_strobe_q <= 1'b1;  // Two counts before the clock falls
                end
                CPU_PHI_END: begin
                    cpu_clock_o <= 1'b0;
                end
                CPU_BE_OFF: begin
                    cpu_be_o <= 1'b0;
                end
                default: begin
                end
            endcase
        end
    end

    assign slot_o.slot          = slot_q;
    // CPU slots use the window strobe instead of slot_valid
    assign slot_o.slot_valid    = slot_start_q && (slot_q != SLOT_CPU_1)
                                  && (slot_q != SLOT_CPU_2);
    assign slot_o.load_sr1      = slot_start_q && (slot_q == SLOT_CPU_1);
    assign slot_o.load_sr2      = slot_start_q
                                  && ((slot_q == SLOT_CPU_1) || (slot_q == SLOT_SPI_1));
    assign slot_o.pixel_en      = pixel_en_q;
    assign slot_o.cpu_wr_strobe = wr_strobe_q;

endmodule

// ==== hw/video_shifter.sv ====
// ********************
// Video output: latest character and attribute bytes, pixel shift register
// Fed by tagged fetches from the bus sequencer
// ********************

module video_shifter import pet_pkg::*; (
    input  logic           sys_clock_i,
    input  logic           rst_i,
    bus_slot_if.shifter    slot_i,
    input  logic           fetch_valid_i,
    input  fetch_kind_e    fetch_kind_i,
    input  logic [7:0]     fetch_data_i,
    output logic           pixel_o,
    output logic [7:0]     attr_o
);

    logic [7:0] char_q;
    logic [7:0] attr_q;
    logic [7:0] shift_q;

    always_ff @(posedge sys_clock_i) begin
        if (rst_i) begin
            char_q <= '0;
            attr_q <= '0;
        end else if (fetch_valid_i) begin
            if (fetch_kind_i == FETCH_CHAR) begin
                char_q <= fetch_data_i;
            end else begin
                attr_q <= fetch_data_i;
            end
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (rst_i) begin
            shift_q <= '0;
        end else if (slot_i.load_sr2) begin
            shift_q <= char_q ^ {8{attr_q[0]}};  // Attribute bit 0 inverts the cell
        end else if (slot_i.pixel_en) begin
            shift_q <= {shift_q[6:0], 1'b0};
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (rst_i) begin
            attr_o <= '0;
        end else if (slot_i.load_sr1) begin
            attr_o <= attr_q;
        end
    end

    assign pixel_o = shift_q[7];  // MSB first

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the pet_core testbench with Verilator, run it and scan the log
set -e
set -o pipefail
cd "$(dirname "$0")"

LOG=sim.log
rm -rf obj_dir
verilator --binary --timing -f build.f --top-module tb_pet_core -o tb_pet_core
./obj_dir/tb_pet_core | tee "$LOG"

if grep -q "Finished with errors" "$LOG"; then
    echo "Simulation failed"
    exit 1
elif ! grep -q "Finished with no errors" "$LOG"; then
    echo "Simulation ended without a result line"
    exit 1
fi
echo "Simulation passed"

// ==== tb/tb_pet_core.sv ====
// ********************
// Testbench for pet_core, one table entry of CPU and SPI traffic per frame
// Compares window, RAM and video outputs with a cycle model every cycle
// ********************

`include "pet_defs.svh"

module tb_pet_core import pet_pkg::*; ();

    localparam int FILL    = 1 << `RAM_AW;  // One CPU write per address first
    localparam int NUM     = FILL + 48;
    localparam int MID     = FILL + 20;     // This frame is cut by a reset
    localparam int TIMEOUT = NUM * 64 * 4 * 2;

    typedef struct packed {
        logic [7:0] addr;
        logic [7:0] data;
        logic       we;
        logic       spi_req;
        logic       spi_late;  // Request raised after SPI_1
        logic [7:0] spi_addr;
        logic [7:0] spi_data;
        logic [7:0] exp_data;
    } frame_t;

    logic        sys_clock_i, rst_i, cpu_we_i, spi_wr_i;
    logic [7:0]  cpu_addr_i, cpu_data_i, spi_addr_i, spi_data_i;
    logic        cpu_be_o, cpu_clock_o, spi_done_o, pixel_o;
    logic [7:0]  cpu_data_o, attr_o;

    frame_t      tbl [NUM];
    logic [7:0]  pre_ram [FILL];    // RAM in table order
    logic [7:0]  ram_model [FILL];  // RAM cycle by cycle
    logic [7:0]  m_ptr, m_char, m_attr, m_shift, m_attr_o, m_cpu_rd, m_fdata;
    logic        m_fv, m_done, saw_done, video_chk;
    fetch_kind_e m_fkind;
    int          c;
    int          seed;
    int          err_bit, err_byte, err_slot;

    pet_core uut (.*);

    initial begin
        sys_clock_i = 1'b0;
        forever #2 sys_clock_i = ~sys_clock_i;
    end

    function automatic logic [7:0] fill_byte(input logic [7:0] a);
        return {a[3:0], a[7:4]} + 8'h5B;
    endfunction

    function automatic bus_owner_e owner_for(input bus_slot_e s);
        if ((s == SLOT_CPU_1) || (s == SLOT_CPU_2)) return OWNER_CPU;
        if ((s == SLOT_SPI_1) || (s == SLOT_SPI_2)) return OWNER_SPI;
        return OWNER_VIDEO;
    endfunction

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            err_bit++;
            $display("** Error: %s at count %0d, expected %b, actual %b", name, c, exp, act);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            err_byte++;
            $display("** Error: %s at count %0d, expected %h, actual %h", name, c, exp, act);
        end
    endtask

    task automatic check_slot(input string name, input bus_slot_e exp, input bus_slot_e act);
        if (act !== exp) begin
            err_slot++;
            $display("** Error: %s at count %0d, expected %s, actual %s",
                     name, c, exp.name(), act.name());
        end
    endtask

    task automatic build_table();
        int r1;
        int r2;
        for (int i = 0; i < NUM; i++) begin
            r1 = $random(seed);
            r2 = $random(seed);
            if (i < FILL) begin
                tbl[i].addr    = 8'(i);
                tbl[i].data    = fill_byte(8'(i));
                tbl[i].we      = 1'b1;
                tbl[i].spi_req = 1'b0;
            end else begin
                tbl[i].addr    = r1[7:0];
                tbl[i].data    = r1[15:8];
                tbl[i].we      = r1[16];
                tbl[i].spi_req = r1[17] && (i != MID);
                if (!r1[16] && tbl[i - 1].spi_req) begin
                    tbl[i].addr = tbl[i - 1].spi_addr;  // Read back the last SPI byte
                end
            end
            tbl[i].spi_late = r1[18];
            tbl[i].spi_addr = r2[7:0];
            tbl[i].spi_data = r2[15:8];
            // CPU access at count 8 comes before either SPI slot
            tbl[i].exp_data = tbl[i].we ? 8'h00 : pre_ram[tbl[i].addr];
            // The cut frame never reaches its CPU access
            if (tbl[i].we && (i != MID)) pre_ram[tbl[i].addr] = tbl[i].data;
            if (tbl[i].spi_req) pre_ram[tbl[i].spi_addr] = tbl[i].spi_data;
        end
    endtask

    // Compare outputs of cycle c, then apply the edge that closes it
    task automatic cycle_compare(input frame_t e);
        logic [2:0] sidx;
        sidx = 3'((c + 63) / 8);  // Slot s covers counts 8s+1 to 8s+8
        check_bit("cpu_be", (c >= 1) && (c <= 12), cpu_be_o);
        check_bit("cpu_clock", (c >= 5) && (c <= 9), cpu_clock_o);
        check_slot("slot", bus_slot_e'(sidx), uut.slot_bus.slot);
        check_bit("spi_done", m_done, spi_done_o);
        check_byte("cpu_data", m_cpu_rd, cpu_data_o);
        if (video_chk && (c % 4 == 1)) check_bit("pixel", m_shift[7], pixel_o);
        if (video_chk) check_byte("attr", m_attr_o, attr_o);
        if (spi_done_o) saw_done = 1'b1;
        if ((c == 1) || (c == 33)) begin
            m_shift = m_attr[0] ? ~m_char : m_char;  // Attribute bit 0 inverts
        end else if (c % 4 == 1) begin
            m_shift = {m_shift[6:0], 1'b0};
        end
        if (c == 1) m_attr_o = m_attr;
        if (m_fv && (m_fkind == FETCH_CHAR)) m_char = m_fdata;
        else if (m_fv) m_attr = m_fdata;
        m_fv   = 1'b0;
        m_done = 1'b0;
        if ((c % 8 == 1) && (owner_for(bus_slot_e'(sidx)) == OWNER_VIDEO)) begin
            m_fv    = 1'b1;
            m_fkind = ((c == 17) || (c == 41)) ? FETCH_CHAR : FETCH_ATTR;
            m_fdata = ram_model[m_ptr];
            m_ptr   = m_ptr + 8'd1;
        end
        if ((c % 8 == 1) && (owner_for(bus_slot_e'(sidx)) == OWNER_SPI) && spi_wr_i) begin
            ram_model[spi_addr_i] = spi_data_i;
            m_done = 1'b1;
        end
        if ((c == 8) && e.we) ram_model[e.addr] = e.data;
        else if (c == 8) m_cpu_rd = e.exp_data;
    endtask

    task automatic run_frame(input frame_t e, input int last);
        for (int n = 0; n <= last; n++) begin
            @(posedge sys_clock_i);
            c = (c + 1) % 64;
            if (saw_done) begin
                spi_wr_i <= 1'b0;  // Requester lets go after the done pulse
                saw_done = 1'b0;
            end
            if (c == 0) begin
                cpu_addr_i <= e.addr;
                cpu_data_i <= e.data;
                cpu_we_i   <= e.we;
            end
            if (e.spi_req && (c == (e.spi_late ? 40 : 0))) begin
                spi_wr_i   <= 1'b1;
                spi_addr_i <= e.spi_addr;
                spi_data_i <= e.spi_data;
            end
            @(negedge sys_clock_i);
            cycle_compare(e);
        end
    endtask

    // RAM keeps its contents through reset
    task automatic restart_model();
        m_ptr    = '0;
        m_char   = '0;
        m_attr   = '0;
        m_shift  = '0;
        m_attr_o = '0;
        m_cpu_rd = '0;
        m_fv     = 1'b0;
        m_done   = 1'b0;
        saw_done = 1'b0;
        c        = 63;
        @(negedge sys_clock_i);
        check_bit("pixel after reset", 1'b0, pixel_o);
        check_byte("attr after reset", 8'h00, attr_o);
        cycle_compare('0);
    endtask

    task automatic mid_reset();
        @(posedge sys_clock_i);
        rst_i <= 1'b1;
        repeat (8) @(posedge sys_clock_i);
        rst_i <= 1'b0;
        restart_model();
    endtask

    initial begin
        seed       = 76;
        err_bit    = 0;
        err_byte   = 0;
        err_slot   = 0;
        video_chk  = 1'b0;
        rst_i      <= 1'b1;
        cpu_addr_i <= '0;
        cpu_data_i <= '0;
        cpu_we_i   <= 1'b0;
        spi_wr_i   <= 1'b0;
        spi_addr_i <= '0;
        spi_data_i <= '0;
        build_table();
        repeat (8) @(posedge sys_clock_i);
        rst_i <= 1'b0;
        restart_model();
        for (int i = 0; i < NUM; i++) begin
            video_chk = (i >= FILL + 2);  // Shifter holds written bytes only
            if (i == MID) begin
                run_frame(tbl[i], 6);  // Reset lands while BE and clock are high
                mid_reset();
            end else begin
                run_frame(tbl[i], 63);
            end
        end
        $display("Error count: bit %0d, byte %0d, slot %0d", err_bit, err_byte, err_slot);
        if ((err_bit + err_byte + err_slot) == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT);
        $display("Run timed out after %0d time units before the table ended", TIMEOUT);
        $display("Error count: bit %0d, byte %0d, slot %0d", err_bit, err_byte, err_slot);
        $display("Finished with errors");
        $finish;
    end

endmodule
